//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module id_stage_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vid_stage_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- sim.f
source/id_pkg.sv
source/id_slot_latch.sv
source/delay_slot_tracker.sv
source/operand_bypass.sv
source/load_hazard_check.sv
source/id_stage.sv
testbench/id_stage_props.sv
testbench/id_stage_tb.sv

//--- source/delay_slot_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module delay_slot_tracker (
    input  wire             clk,
    input  wire             rst_i,
    input  wire             exception_flag_i,
    input  wire             branch_flag_i,
    input  wire             transfer_i,
    input  wire             valid_secondary_i,
    input  id_pkg::alusel_t alusel_primary_i,
    output logic            flush_all_o,
    output logic            flush_secondary_o,
    output logic            in_delayslot_primary_o,
    output logic            in_delayslot_secondary_o
);

    logic delayslot;
    logic primary_is_branch;

    assign primary_is_branch = (alusel_primary_i == id_pkg::ALUSEL_BRANCH) ||
                               (alusel_primary_i == id_pkg::ALUSEL_LIKELY);

    // branch went out alone, so its delay slot is still to come
    always_ff @(posedge clk) begin
        if (rst_i || exception_flag_i) begin
            delayslot <= 1'b0;
        end else if (transfer_i) begin
            delayslot <= !valid_secondary_i && primary_is_branch;
        end
    end

    // keep the delay slot, drop everything behind it
    assign flush_all_o       = exception_flag_i || (branch_flag_i && !delayslot);
    assign flush_secondary_o = branch_flag_i && delayslot;

    assign in_delayslot_primary_o   = delayslot;
    assign in_delayslot_secondary_o = primary_is_branch;

endmodule

`default_nettype wire

//--- source/id_pkg.sv
`default_nettype none

package id_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALUOP_W    = 8;
    localparam int FWD_PORTS  = 8;
    localparam int LOAD_SRCS  = 4;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [ALUOP_W-1:0]    aluop_t;

    // alu class, only branch and likely matter in decode
    typedef enum logic [3:0] {
        ALUSEL_NOP    = 4'h0,
        ALUSEL_LOGIC  = 4'h1,
        ALUSEL_SHIFT  = 4'h2,
        ALUSEL_MOVE   = 4'h3,
        ALUSEL_ARITH  = 4'h4,
        ALUSEL_MUL    = 4'h5,
        ALUSEL_BRANCH = 4'h6,
        ALUSEL_LIKELY = 4'h7,
        ALUSEL_LOAD   = 4'h8,
        ALUSEL_STORE  = 4'h9
    } alusel_t;

    typedef enum logic [1:0] {
        ISSUE_NONE   = 2'd0,
        ISSUE_SINGLE = 2'd1,
        ISSUE_DOUBLE = 2'd2
    } issue_mode_t;

    // --------------------
    // pipeline payloads
    // --------------------
    typedef struct packed {
        word_t     inst_addr;
        logic      reg_write;
        reg_addr_t reg_waddr;
        alusel_t   alusel;
        aluop_t    aluop;
        logic      reg1_read;
        reg_addr_t reg1_addr;
        logic      reg2_read;
        reg_addr_t reg2_addr;
        word_t     imm;
    } issue_slot_t;

    typedef struct packed {
        logic      valid;
        word_t     inst_addr;
        logic      reg_write;
        reg_addr_t reg_waddr;
        alusel_t   alusel;
        aluop_t    aluop;
        word_t     opdata1;
        word_t     opdata2;
        logic      in_delayslot;
    } ex_slot_t;

    // --------------------
    // bypass and hazard
    // --------------------
    typedef struct packed {
        logic      wen;
        reg_addr_t waddr;
        word_t     wdata;
    } fwd_port_t;

    // index 0 wins: ex2, ex1, mem1_2, mem1_1, mem2_2, mem2_1, wb2, wb1
    typedef fwd_port_t [FWD_PORTS-1:0] fwd_bus_t;

    // load still in flight, result not forwardable yet
    typedef struct packed {
        logic      pending;
        reg_addr_t waddr;
    } load_src_t;

    // ex primary, ex secondary, mem1, mem2
    typedef load_src_t [LOAD_SRCS-1:0] load_bus_t;

    typedef struct packed {
        word_t rdata1;
        word_t rdata2;
    } rf_pair_t;

    typedef struct packed {
        reg_addr_t rs;
        reg_addr_t rt;
    } rsrt_t;

endpackage

`default_nettype wire

//--- source/id_slot_latch.sv
`timescale 1ns/100ps
`default_nettype none

module id_slot_latch (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire                 flush_all_i,
    input  wire                 flush_secondary_i,
    input  wire                 branch_flag_i,
    input  wire                 hazard_primary_i,
    input  wire                 hazard_secondary_i,
    input  wire                 ex_allowin_i,
    input  id_pkg::issue_mode_t issue_mode_i,
    input  id_pkg::issue_slot_t slot_primary_i,
    input  id_pkg::issue_slot_t slot_secondary_i,
    output id_pkg::issue_slot_t slot_primary_o,
    output id_pkg::issue_slot_t slot_secondary_o,
    output logic                valid_primary_o,
    output logic                valid_secondary_o,
    output logic                id_allowin_o,
    output logic                id_ex_valid_o
);

    logic                valid_primary;
    logic                valid_secondary;
    logic                ready_go;
    logic                allowin;
    logic                issue_any;
    logic                issue_double;
    id_pkg::issue_slot_t slot_primary;
    id_pkg::issue_slot_t slot_secondary;

    assign issue_any    = (issue_mode_i != id_pkg::ISSUE_NONE);
    assign issue_double = (issue_mode_i == id_pkg::ISSUE_DOUBLE);

    // --------------------
    // handshake
    // --------------------
    // a pending branch resolve also holds the stage
    assign ready_go = !hazard_primary_i && !hazard_secondary_i && !branch_flag_i;
    assign allowin  = !valid_primary || (ready_go && ex_allowin_i);

    always_ff @(posedge clk) begin
        if (rst_i || flush_all_i) begin
            valid_primary <= 1'b0;
        end else if (allowin) begin
            valid_primary <= issue_any;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_all_i || flush_secondary_i) begin
            valid_secondary <= 1'b0;
        end else if (allowin) begin
            valid_secondary <= issue_double;
        end
    end

    // --------------------
    // slot payload
    // --------------------
    always_ff @(posedge clk) begin
        if (allowin && issue_any) begin
            slot_primary <= slot_primary_i;
            // single issue leaves a clean secondary
            slot_secondary <= issue_double ? slot_secondary_i : '0;
        end
    end

    assign slot_primary_o    = slot_primary;
    assign slot_secondary_o  = slot_secondary;
    assign valid_primary_o   = valid_primary;
    assign valid_secondary_o = valid_secondary;
    assign id_allowin_o      = allowin;
    assign id_ex_valid_o     = valid_primary && ready_go;

endmodule

`default_nettype wire

//--- source/id_stage.sv
`timescale 1ns/100ps
`default_nettype none

module id_stage (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire                 branch_flag_i,
    input  wire                 exception_flag_i,
    input  wire                 ex_allowin_i,
    input  id_pkg::issue_mode_t issue_mode_i,
    input  id_pkg::issue_slot_t slot_primary_i,
    input  id_pkg::issue_slot_t slot_secondary_i,
    input  id_pkg::fwd_bus_t    fwd_i,
    input  id_pkg::load_bus_t   loads_i,
    input  id_pkg::rf_pair_t    rf_primary_i,
    input  id_pkg::rf_pair_t    rf_secondary_i,
    output logic                id_allowin_o,
    output logic                id_ex_valid_o,
    output id_pkg::ex_slot_t    ex_primary_o,
    output id_pkg::ex_slot_t    ex_secondary_o,
    output id_pkg::rsrt_t       rsrt_primary_o,
    output id_pkg::rsrt_t       rsrt_secondary_o
);

    id_pkg::issue_slot_t slot_primary;
    id_pkg::issue_slot_t slot_secondary;
    logic                valid_primary;
    logic                valid_secondary;
    logic                hazard_primary;
    logic                hazard_secondary;
    logic                flush_all;
    logic                flush_secondary;
    logic                transfer;
    logic                in_delayslot_primary;
    logic                in_delayslot_secondary;
    id_pkg::word_t       opdata1_primary;
    id_pkg::word_t       opdata2_primary;
    id_pkg::word_t       opdata1_secondary;
    id_pkg::word_t       opdata2_secondary;

    assign transfer = id_ex_valid_o && ex_allowin_i;

    // --------------------
    // issue latch
    // --------------------
    id_slot_latch u_latch (
        .clk                (clk),
        .rst_i              (rst_i),
        .flush_all_i        (flush_all),
        .flush_secondary_i  (flush_secondary),
        .branch_flag_i      (branch_flag_i),
        .hazard_primary_i   (hazard_primary),
        .hazard_secondary_i (hazard_secondary),
        .ex_allowin_i       (ex_allowin_i),
        .issue_mode_i       (issue_mode_i),
        .slot_primary_i     (slot_primary_i),
        .slot_secondary_i   (slot_secondary_i),
        .slot_primary_o     (slot_primary),
        .slot_secondary_o   (slot_secondary),
        .valid_primary_o    (valid_primary),
        .valid_secondary_o  (valid_secondary),
        .id_allowin_o       (id_allowin_o),
        .id_ex_valid_o      (id_ex_valid_o)
    );

    delay_slot_tracker u_delay (
        .clk                      (clk),
        .rst_i                    (rst_i),
        .exception_flag_i         (exception_flag_i),
        .branch_flag_i            (branch_flag_i),
        .transfer_i               (transfer),
        .valid_secondary_i        (valid_secondary),
        .alusel_primary_i         (slot_primary.alusel),
        .flush_all_o              (flush_all),
        .flush_secondary_o        (flush_secondary),
        .in_delayslot_primary_o   (in_delayslot_primary),
        .in_delayslot_secondary_o (in_delayslot_secondary)
    );

    // --------------------
    // per-lane operands and stalls
    // --------------------
    operand_bypass u_bypass_primary (
        .slot_i    (slot_primary),
        .fwd_i     (fwd_i),
        .rf_i      (rf_primary_i),
        .opdata1_o (opdata1_primary),
        .opdata2_o (opdata2_primary)
    );

    operand_bypass u_bypass_secondary (
        .slot_i    (slot_secondary),
        .fwd_i     (fwd_i),
        .rf_i      (rf_secondary_i),
        .opdata1_o (opdata1_secondary),
        .opdata2_o (opdata2_secondary)
    );

    load_hazard_check u_hazard_primary (
        .slot_i   (slot_primary),
        .loads_i  (loads_i),
        .hazard_o (hazard_primary)
    );

    load_hazard_check u_hazard_secondary (
        .slot_i   (slot_secondary),
        .loads_i  (loads_i),
        .hazard_o (hazard_secondary)
    );

    // register file reads straight from the latched slots
    assign rsrt_primary_o.rs   = slot_primary.reg1_addr;
    assign rsrt_primary_o.rt   = slot_primary.reg2_addr;
    assign rsrt_secondary_o.rs = slot_secondary.reg1_addr;
    assign rsrt_secondary_o.rt = slot_secondary.reg2_addr;

    // --------------------
    // execute payloads
    // --------------------
    always_comb begin
        ex_primary_o = '0;
        if (valid_primary) begin
            ex_primary_o.valid        = 1'b1;
            ex_primary_o.inst_addr    = slot_primary.inst_addr;
            ex_primary_o.reg_write    = slot_primary.reg_write;
            ex_primary_o.reg_waddr    = slot_primary.reg_waddr;
            ex_primary_o.alusel       = slot_primary.alusel;
            ex_primary_o.aluop        = slot_primary.aluop;
            ex_primary_o.opdata1      = opdata1_primary;
            ex_primary_o.opdata2      = opdata2_primary;
            ex_primary_o.in_delayslot = in_delayslot_primary;
        end
    end

    always_comb begin
        ex_secondary_o = '0;
        if (valid_secondary) begin
            ex_secondary_o.valid        = 1'b1;
            ex_secondary_o.inst_addr    = slot_secondary.inst_addr;
            ex_secondary_o.reg_write    = slot_secondary.reg_write;
            ex_secondary_o.reg_waddr    = slot_secondary.reg_waddr;
            ex_secondary_o.alusel       = slot_secondary.alusel;
            ex_secondary_o.aluop        = slot_secondary.aluop;
            ex_secondary_o.opdata1      = opdata1_secondary;
            ex_secondary_o.opdata2      = opdata2_secondary;
            ex_secondary_o.in_delayslot = in_delayslot_secondary;
        end
    end

endmodule

`default_nettype wire

//--- source/load_hazard_check.sv
`timescale 1ns/100ps
`default_nettype none

module load_hazard_check (
    input  id_pkg::issue_slot_t slot_i,
    input  id_pkg::load_bus_t   loads_i,
    output logic                hazard_o
);

    logic hit1;
    logic hit2;

    function automatic logic load_hit(
        input logic              read_en,
        input id_pkg::reg_addr_t raddr,
        input id_pkg::load_bus_t loads
    );
        logic match;
        match = 1'b0;
        for (int i = 0; i < id_pkg::LOAD_SRCS; i++) begin
            if (loads[i].pending && (loads[i].waddr == raddr)) begin
                match = 1'b1;
            end
        end
        // $zero never waits on a load
        return read_en && (raddr != '0) && match;
    endfunction

    assign hit1 = load_hit(slot_i.reg1_read, slot_i.reg1_addr, loads_i);
    assign hit2 = load_hit(slot_i.reg2_read, slot_i.reg2_addr, loads_i);

    assign hazard_o = hit1 || hit2;

endmodule

`default_nettype wire

//--- source/operand_bypass.sv
`timescale 1ns/100ps
`default_nettype none

module operand_bypass (
    input  id_pkg::issue_slot_t slot_i,
    input  id_pkg::fwd_bus_t    fwd_i,
    input  id_pkg::rf_pair_t    rf_i,
    output id_pkg::word_t       opdata1_o,
    output id_pkg::word_t       opdata2_o
);

    // immediate, else first matching forward port, else register file
    function automatic id_pkg::word_t pick_operand(
        input logic              read_en,
        input id_pkg::reg_addr_t raddr,
        input id_pkg::word_t     imm,
        input id_pkg::word_t     rf_data,
        input id_pkg::fwd_bus_t  fwd
    );
        id_pkg::word_t result;
        result = rf_data;
        // walk upward in index order reversed so port 0 lands last
        for (int i = id_pkg::FWD_PORTS - 1; i >= 0; i--) begin
            if (fwd[i].wen && (fwd[i].waddr == raddr)) begin
                result = fwd[i].wdata;
            end
        end
        if (!read_en) begin
            result = imm;
        end
        return result;
    endfunction

    assign opdata1_o = pick_operand(
        slot_i.reg1_read,
        slot_i.reg1_addr,
        slot_i.imm,
        rf_i.rdata1,
        fwd_i
    );

    assign opdata2_o = pick_operand(
        slot_i.reg2_read,
        slot_i.reg2_addr,
        slot_i.imm,
        rf_i.rdata2,
        fwd_i
    );

endmodule

`default_nettype wire

//--- testbench/id_stage_props.sv
`timescale 1ns/100ps
`default_nettype none

module id_stage_props (
    input wire              clk,
    input wire              rst_i,
    input wire              branch_flag_i,
    input wire              exception_flag_i,
    input wire              ex_allowin_i,
    input wire              ex_valid_i,
    input id_pkg::ex_slot_t primary_i,
    input id_pkg::ex_slot_t secondary_i
);

    // stage comes out of reset empty
    reset_empty: assert property (
        @(posedge clk) rst_i |=> (!primary_i.valid && !secondary_i.valid && !ex_valid_i)
    ) else $error("slot still valid in the cycle after reset");

    branch_blocks: assert property (
        @(posedge clk) disable iff (rst_i) branch_flag_i |-> !ex_valid_i
    ) else $error("stage offered a slot to execute while a branch was resolving");

    // --------------------
    // back-pressure
    // --------------------
    // operands may follow the forwarding ports, the instruction itself may not
    held_stable: assert property (
        @(posedge clk) disable iff (rst_i)
        (primary_i.valid && !ex_allowin_i && !branch_flag_i && !exception_flag_i)
        |=> (primary_i.valid &&
             $stable(primary_i.inst_addr) &&
             $stable(primary_i.alusel) &&
             $stable(primary_i.aluop) &&
             $stable(secondary_i.inst_addr))
    ) else $error("held slot changed while execute was not accepting");

endmodule

`default_nettype wire

//--- testbench/id_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module id_stage_tb;

    logic                clk;
    logic                rst_i;
    logic                branch_flag_i;
    logic                exception_flag_i;
    logic                ex_allowin_i;
    id_pkg::issue_mode_t issue_mode_i;
    id_pkg::issue_slot_t slot_primary_i;
    id_pkg::issue_slot_t slot_secondary_i;
    id_pkg::fwd_bus_t    fwd_i;
    id_pkg::load_bus_t   loads_i;
    id_pkg::rf_pair_t    rf_primary_i;
    id_pkg::rf_pair_t    rf_secondary_i;
    logic                id_allowin_o;
    logic                id_ex_valid_o;
    id_pkg::ex_slot_t    ex_primary_o;
    id_pkg::ex_slot_t    ex_secondary_o;
    id_pkg::rsrt_t       rsrt_primary_o;
    id_pkg::rsrt_t       rsrt_secondary_o;

    id_pkg::rf_pair_t    rf_p;
    id_pkg::rf_pair_t    rf_s;
    string               test_name;
    int                  seed = 18153;
    int                  errors = 0;
    int                  checks = 0;
    int                  test_count = 5;

    id_stage uut (
        .clk              (clk),
        .rst_i            (rst_i),
        .branch_flag_i    (branch_flag_i),
        .exception_flag_i (exception_flag_i),
        .ex_allowin_i     (ex_allowin_i),
        .issue_mode_i     (issue_mode_i),
        .slot_primary_i   (slot_primary_i),
        .slot_secondary_i (slot_secondary_i),
        .fwd_i            (fwd_i),
        .loads_i          (loads_i),
        .rf_primary_i     (rf_primary_i),
        .rf_secondary_i   (rf_secondary_i),
        .id_allowin_o     (id_allowin_o),
        .id_ex_valid_o    (id_ex_valid_o),
        .ex_primary_o     (ex_primary_o),
        .ex_secondary_o   (ex_secondary_o),
        .rsrt_primary_o   (rsrt_primary_o),
        .rsrt_secondary_o (rsrt_secondary_o)
    );

    bind id_stage id_stage_props u_props (
        .clk              (clk),
        .rst_i            (rst_i),
        .branch_flag_i    (branch_flag_i),
        .exception_flag_i (exception_flag_i),
        .ex_allowin_i     (ex_allowin_i),
        .ex_valid_i       (id_ex_valid_o),
        .primary_i        (ex_primary_o),
        .secondary_i      (ex_secondary_o)
    );

    always #4 clk = ~clk;

    // --------------------
    // helpers
    // --------------------
    function automatic id_pkg::issue_slot_t make_slot(
        input id_pkg::word_t     addr,
        input id_pkg::alusel_t   sel,
        input logic              rd1,
        input id_pkg::reg_addr_t ra1,
        input logic              rd2,
        input id_pkg::reg_addr_t ra2,
        input id_pkg::word_t     imm
    );
        id_pkg::issue_slot_t s;
        s           = '0;
        s.inst_addr = addr;
        s.reg_write = 1'b1;
        s.reg_waddr = addr[6:2];
        s.alusel    = sel;
        s.aluop     = addr[9:2];
        s.reg1_read = rd1;
        s.reg1_addr = ra1;
        s.reg2_read = rd2;
        s.reg2_addr = ra2;
        s.imm       = imm;
        return s;
    endfunction

    // what execute should see for a valid slot
    function automatic id_pkg::ex_slot_t expect_slot(
        input id_pkg::issue_slot_t s,
        input id_pkg::word_t       op1,
        input id_pkg::word_t       op2,
        input logic                dly
    );
        id_pkg::ex_slot_t e;
        e              = '0;
        e.valid        = 1'b1;
        e.inst_addr    = s.inst_addr;
        e.reg_write    = s.reg_write;
        e.reg_waddr    = s.reg_waddr;
        e.alusel       = s.alusel;
        e.aluop        = s.aluop;
        e.opdata1      = op1;
        e.opdata2      = op2;
        e.in_delayslot = dly;
        return e;
    endfunction

    function automatic id_pkg::fwd_port_t fwd_entry(
        input id_pkg::reg_addr_t a,
        input id_pkg::word_t     d
    );
        id_pkg::fwd_port_t f;
        f.wen   = 1'b1;
        f.waddr = a;
        f.wdata = d;
        return f;
    endfunction

    function automatic id_pkg::load_src_t load_entry(input id_pkg::reg_addr_t a);
        id_pkg::load_src_t l;
        l.pending = 1'b1;
        l.waddr   = a;
        return l;
    endfunction

    function automatic id_pkg::rsrt_t make_rsrt(
        input id_pkg::reg_addr_t rs,
        input id_pkg::reg_addr_t rt
    );
        id_pkg::rsrt_t r;
        r.rs = rs;
        r.rt = rt;
        return r;
    endfunction

    task automatic check_slot(input string what, input id_pkg::ex_slot_t exp,
                              input id_pkg::ex_slot_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH [%s] %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_word(input string what, input id_pkg::word_t exp,
                              input id_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH [%s] %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH [%s] %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_rsrt(input string what, input id_pkg::rsrt_t exp,
                              input id_pkg::rsrt_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH [%s] %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // present an issue with fresh rf data, wait for acceptance, then go idle
    task automatic issue(input id_pkg::issue_mode_t mode, input id_pkg::issue_slot_t p,
                         input id_pkg::issue_slot_t s, input logic allow);
        int waited;
        waited      = 0;
        rf_p.rdata1 = $random(seed);
        rf_p.rdata2 = $random(seed);
        rf_s.rdata1 = $random(seed);
        rf_s.rdata2 = $random(seed);
        @(posedge clk);
        issue_mode_i     <= mode;
        slot_primary_i   <= p;
        slot_secondary_i <= s;
        ex_allowin_i     <= allow;
        rf_primary_i     <= rf_p;
        rf_secondary_i   <= rf_s;
        @(negedge clk);
        while (!id_allowin_o && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (!id_allowin_o) begin
            errors++;
            $display("ERROR [%s] issue was not accepted within 50 cycles", test_name);
        end
        @(posedge clk);
        issue_mode_i <= id_pkg::ISSUE_NONE;
        @(negedge clk);
    endtask

    // --------------------
    // tests
    // --------------------
    task automatic test_issue();
        id_pkg::issue_slot_t a;
        id_pkg::issue_slot_t b;
        id_pkg::issue_slot_t c;
        id_pkg::issue_slot_t junk;
        test_name = "issue";
        a    = make_slot(32'h0040_0100, id_pkg::ALUSEL_ARITH, 1'b1, 5'd3, 1'b0, 5'd4, 32'h1234);
        junk = make_slot(32'hdead_0000, id_pkg::ALUSEL_STORE, 1'b1, 5'd31, 1'b1, 5'd30, '1);
        issue(id_pkg::ISSUE_SINGLE, a, junk, 1'b1);
        check_bit("id_ex_valid", 1'b1, id_ex_valid_o);
        check_slot("single primary", expect_slot(a, rf_p.rdata1, a.imm, 1'b0), ex_primary_o);
        check_slot("single secondary", '0, ex_secondary_o);
        check_rsrt("rsrt primary", make_rsrt(5'd3, 5'd4), rsrt_primary_o);
        check_rsrt("rsrt secondary single", make_rsrt(5'd0, 5'd0), rsrt_secondary_o);

        b = make_slot(32'h0040_0104, id_pkg::ALUSEL_LOGIC, 1'b1, 5'd5, 1'b1, 5'd6, 32'h77);
        c = make_slot(32'h0040_0108, id_pkg::ALUSEL_SHIFT, 1'b1, 5'd7, 1'b0, 5'd8, 32'h1f);
        issue(id_pkg::ISSUE_DOUBLE, b, c, 1'b1);
        check_slot("double primary", expect_slot(b, rf_p.rdata1, rf_p.rdata2, 1'b0),
                   ex_primary_o);
        check_slot("double secondary", expect_slot(c, rf_s.rdata1, c.imm, 1'b0),
                   ex_secondary_o);
        check_rsrt("rsrt secondary", make_rsrt(5'd7, 5'd8), rsrt_secondary_o);
    endtask

    task automatic test_forward();
        id_pkg::issue_slot_t d;
        test_name = "forward";
        d = make_slot(32'h0040_0200, id_pkg::ALUSEL_ARITH, 1'b1, 5'd9, 1'b1, 5'd10, 32'h5);
        @(posedge clk);
        fwd_i[6]       <= fwd_entry(5'd9, 32'h6666_0006);
        fwd_i[5]       <= fwd_entry(5'd9, 32'h5555_0005);
        fwd_i[2]       <= fwd_entry(5'd9, 32'h2222_0002);
        fwd_i[1].waddr <= 5'd10;
        fwd_i[1].wdata <= 32'h1111_0001;
        issue(id_pkg::ISSUE_SINGLE, d, '0, 1'b0);
        check_word("opdata1 lowest match", 32'h2222_0002, ex_primary_o.opdata1);
        check_word("opdata2 from rf", rf_p.rdata2, ex_primary_o.opdata2);
        // held slot picks up a new forward in the same cycle
        @(posedge clk);
        fwd_i[0] <= fwd_entry(5'd9, 32'h0000_f000);
        fwd_i[3] <= fwd_entry(5'd10, 32'h3333_0003);
        @(negedge clk);
        check_word("opdata1 port 0", 32'h0000_f000, ex_primary_o.opdata1);
        check_word("opdata2 port 3", 32'h3333_0003, ex_primary_o.opdata2);
        @(posedge clk);
        fwd_i        <= '0;
        ex_allowin_i <= 1'b1;
        @(negedge clk);
        check_word("opdata1 no match", rf_p.rdata1, ex_primary_o.opdata1);
    endtask

    task automatic test_load_stall();
        id_pkg::issue_slot_t e;
        id_pkg::issue_slot_t f;
        test_name = "load_stall";
        e = make_slot(32'h0040_0300, id_pkg::ALUSEL_ARITH, 1'b1, 5'd1, 1'b1, 5'd9, 32'h0);
        f = make_slot(32'h0040_0304, id_pkg::ALUSEL_ARITH, 1'b1, 5'd0, 1'b0, 5'd0, 32'h8);
        @(posedge clk);
        loads_i[2] <= load_entry(5'd9);
        issue(id_pkg::ISSUE_SINGLE, e, '0, 1'b1);
        repeat (3) begin
            check_bit("id_ex_valid stalled", 1'b0, id_ex_valid_o);
            check_bit("id_allowin stalled", 1'b0, id_allowin_o);
            @(negedge clk);
        end
        check_slot("stalled primary", expect_slot(e, rf_p.rdata1, rf_p.rdata2, 1'b0),
                   ex_primary_o);
        @(posedge clk);
        loads_i <= '0;
        @(negedge clk);
        check_bit("id_ex_valid released", 1'b1, id_ex_valid_o);
        check_bit("id_allowin released", 1'b1, id_allowin_o);

        // loads to $zero never stall
        @(posedge clk);
        loads_i[0] <= load_entry(5'd0);
        issue(id_pkg::ISSUE_SINGLE, f, '0, 1'b1);
        check_bit("id_ex_valid r0 load", 1'b1, id_ex_valid_o);
        @(posedge clk);
        loads_i <= '0;
    endtask

    task automatic test_backpressure();
        id_pkg::issue_slot_t g;
        id_pkg::issue_slot_t h;
        id_pkg::ex_slot_t    held;
        test_name = "backpressure";
        g = make_slot(32'h0040_0400, id_pkg::ALUSEL_MOVE, 1'b1, 5'd11, 1'b1, 5'd12, 32'h9);
        h = make_slot(32'h0040_0480, id_pkg::ALUSEL_LOAD, 1'b1, 5'd13, 1'b0, 5'd14, 32'hc);
        issue(id_pkg::ISSUE_SINGLE, g, '0, 1'b0);
        held = expect_slot(g, rf_p.rdata1, rf_p.rdata2, 1'b0);
        for (int i = 0; i < 4; i++) begin
            h.inst_addr = h.inst_addr + 32'd4;
            @(posedge clk);
            issue_mode_i     <= (i % 2 == 1) ? id_pkg::ISSUE_DOUBLE : id_pkg::ISSUE_SINGLE;
            slot_primary_i   <= h;
            slot_secondary_i <= h;
            @(negedge clk);
            check_bit("id_allowin held", 1'b0, id_allowin_o);
            check_bit("id_ex_valid held", 1'b1, id_ex_valid_o);
            check_slot("held primary", held, ex_primary_o);
            check_slot("held secondary", '0, ex_secondary_o);
        end
        @(posedge clk);
        issue_mode_i <= id_pkg::ISSUE_NONE;
        ex_allowin_i <= 1'b1;
        @(negedge clk);
        check_bit("id_allowin resumed", 1'b1, id_allowin_o);
    endtask

    task automatic test_flush();
        id_pkg::issue_slot_t j;
        id_pkg::issue_slot_t k;
        id_pkg::issue_slot_t br;
        id_pkg::issue_slot_t ds;
        id_pkg::issue_slot_t nx;
        test_name = "flush";
        j  = make_slot(32'h0040_0500, id_pkg::ALUSEL_ARITH, 1'b1, 5'd2, 1'b1, 5'd3, 32'h1);
        k  = make_slot(32'h0040_0504, id_pkg::ALUSEL_LOGIC, 1'b1, 5'd4, 1'b0, 5'd5, 32'h2);
        br = make_slot(32'h0040_0600, id_pkg::ALUSEL_BRANCH, 1'b1, 5'd13, 1'b1, 5'd14, 32'h40);
        ds = make_slot(32'h0040_0604, id_pkg::ALUSEL_ARITH, 1'b1, 5'd15, 1'b0, 5'd0, 32'h3);
        nx = make_slot(32'h0040_0608, id_pkg::ALUSEL_SHIFT, 1'b1, 5'd16, 1'b1, 5'd17, 32'h4);

        // exception empties both slots
        issue(id_pkg::ISSUE_DOUBLE, j, k, 1'b0);
        check_bit("secondary valid", 1'b1, ex_secondary_o.valid);
        @(posedge clk);
        exception_flag_i <= 1'b1;
        @(posedge clk);
        exception_flag_i <= 1'b0;
        @(negedge clk);
        check_slot("exception primary", '0, ex_primary_o);
        check_slot("exception secondary", '0, ex_secondary_o);
        check_bit("id_ex_valid after exception", 1'b0, id_ex_valid_o);

        // lone branch whose delay slot comes next as primary
        issue(id_pkg::ISSUE_SINGLE, br, '0, 1'b1);
        check_slot("branch primary", expect_slot(br, rf_p.rdata1, rf_p.rdata2, 1'b0),
                   ex_primary_o);
        issue(id_pkg::ISSUE_DOUBLE, ds, nx, 1'b0);
        check_slot("delay slot primary", expect_slot(ds, rf_p.rdata1, ds.imm, 1'b1),
                   ex_primary_o);
        check_slot("delay slot secondary", expect_slot(nx, rf_s.rdata1, rf_s.rdata2, 1'b0),
                   ex_secondary_o);
        @(posedge clk);
        branch_flag_i <= 1'b1;
        @(negedge clk);
        check_bit("id_ex_valid under branch", 1'b0, id_ex_valid_o);
        @(posedge clk);
        branch_flag_i <= 1'b0;
        @(negedge clk);
        check_slot("kept delay slot", expect_slot(ds, rf_p.rdata1, ds.imm, 1'b1), ex_primary_o);
        check_slot("killed secondary", '0, ex_secondary_o);

        // branch issued in pairs carries its delay slot along
        j = make_slot(32'h0040_0700, id_pkg::ALUSEL_LIKELY, 1'b1, 5'd18, 1'b1, 5'd19, 32'h80);
        k = make_slot(32'h0040_0704, id_pkg::ALUSEL_ARITH, 1'b0, 5'd0, 1'b1, 5'd20, 32'h5);
        issue(id_pkg::ISSUE_DOUBLE, j, k, 1'b1);
        check_slot("paired branch", expect_slot(j, rf_p.rdata1, rf_p.rdata2, 1'b0),
                   ex_primary_o);
        check_slot("paired delay slot", expect_slot(k, k.imm, rf_s.rdata2, 1'b1),
                   ex_secondary_o);
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        clk              = 1'b0;
        rst_i            = 1'b1;
        branch_flag_i    = 1'b0;
        exception_flag_i = 1'b0;
        ex_allowin_i     = 1'b1;
        issue_mode_i     = id_pkg::ISSUE_NONE;
        slot_primary_i   = '0;
        slot_secondary_i = '0;
        fwd_i            = '0;
        loads_i          = '0;
        rf_primary_i     = '0;
        rf_secondary_i   = '0;
        repeat (8) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        test_name = "reset";
        check_bit("id_allowin after reset", 1'b1, id_allowin_o);
        check_bit("id_ex_valid after reset", 1'b0, id_ex_valid_o);
        test_issue();
        test_forward();
        test_load_stall();
        test_backpressure();
        test_flush();
        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        limit = 8 + 200 * test_count;
        repeat (limit) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, the run did not complete", limit);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire
